// File: rtl/fetch_pkg.sv
// fetch front end shared definitions
// widths, reset pc, rv32i opcode constants and state/class enums
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] addr_t;      // byte address
	typedef logic [31:0] word_t;      // instruction word
	typedef logic [7:0]  imem_idx_t;  // ram word index, addr bits 9:2

	localparam int    IMEM_WORDS = 256;
	localparam addr_t RESET_PC   = 32'h8000_0000;  // maps to index 0

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;

	// whole-word encodings, all register fields zero
	localparam word_t ECALL_WORD  = {25'h0, OPC_SYSTEM};
	localparam word_t EBREAK_WORD = {12'h001, 13'h0, OPC_SYSTEM};
	localparam word_t MRET_WORD   = {12'h302, 13'h0, OPC_SYSTEM};
	localparam word_t FENCEI_WORD = {17'h0, 3'b001, 5'h0, OPC_MISC_MEM};

	typedef enum logic [2:0] {
		CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JUMP, CLS_SYSTEM, CLS_ILLEGAL
	} inst_class_t;

	typedef enum logic [1:0] {
		IFU_IDLE, IFU_SETUP, IFU_ACCESS, IFU_HALT
	} ifu_state_t;

endpackage

`default_nettype wire

// File: rtl/apb_rd_if.sv
// apb read channel, fetch stage master to instruction ram slave
`timescale 1ns/10ps
`default_nettype none

interface apb_rd_if;
	import fetch_pkg::*;

	logic  psel;
	logic  penable;
	addr_t paddr;    // held stable through access phase
	word_t prdata;   // valid with pready
	logic  pready;

	modport master (
		output psel, penable, paddr,
		input  prdata, pready
	);

	modport slave (
		input  psel, penable, paddr,
		output prdata, pready
	);
endinterface

`default_nettype wire

// File: rtl/fetch_dec_if.sv
// valid/allowin handshake from fetch stage into predecode
`timescale 1ns/10ps
`default_nettype none

interface fetch_dec_if;
	import fetch_pkg::*;

	logic  valid;    // inst/pc meaningful
	logic  allowin;  // predecode can take a word this cycle
	word_t inst;
	addr_t pc;

	modport source (
		output valid, inst, pc,
		input  allowin
	);

	modport sink (
		input  valid, inst, pc,
		output allowin
	);
endinterface

`default_nettype wire

// File: rtl/ifu_stage.sv
// instruction fetch stage
// keeps the pc, runs apb reads one at a time, drops the response of a
// read overtaken by a flush, and parks one word while predecode is full
`timescale 1ns/10ps
`default_nettype none

module ifu_stage (
	input  logic             clock,
	input  logic             reset,
	fetch_dec_if.source      fetch_if,
	apb_rd_if.master         mem_if,
	input  logic             flush_i,
	input  fetch_pkg::addr_t flush_pc_i,
	input  logic             halt_i
);
	import fetch_pkg::*;

	ifu_state_t state_q;
	ifu_state_t state_d;
	addr_t      pc_q;         // next address to fetch
	addr_t      pc_d;
	addr_t      paddr_q;      // address of the read in flight
	logic       stale_q;      // read in flight belongs to the old path
	logic       done;         // apb transfer ends this cycle
	logic       take;         // ...and its data is wanted
	logic       park;         // wanted data but predecode is full
	logic       buf_valid_q;
	word_t      buf_inst_q;
	addr_t      buf_pc_q;

	assign done = (state_q == IFU_ACCESS) && mem_if.pready;
	assign take = done && !stale_q;
	assign park = take && !fetch_if.allowin && !flush_i;

	// apb pins straight off the state
	assign mem_if.psel    = (state_q == IFU_SETUP) || (state_q == IFU_ACCESS);
	assign mem_if.penable = (state_q == IFU_ACCESS);
	assign mem_if.paddr   = paddr_q;

	// buffered word wins, else the live response passes through
	assign fetch_if.valid = buf_valid_q || take;
	assign fetch_if.inst  = buf_valid_q ? buf_inst_q : mem_if.prdata;
	assign fetch_if.pc    = buf_valid_q ? buf_pc_q : paddr_q;

	// redirect beats sequential advance
	assign pc_d = flush_i ? flush_pc_i : (take ? pc_q + 32'd4 : pc_q);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IFU_IDLE: begin
				if (halt_i)
					state_d = IFU_HALT;
				else if (!buf_valid_q || fetch_if.allowin || flush_i)
					state_d = IFU_SETUP;  // buffer empty or draining now
			end
			IFU_SETUP: state_d = IFU_ACCESS;  // setup is always one cycle
			IFU_ACCESS: begin
				if (mem_if.pready) begin
					if (halt_i)
						state_d = IFU_HALT;
					else if (stale_q || flush_i || fetch_if.allowin)
						state_d = IFU_SETUP;  // back to back read
					else
						state_d = IFU_IDLE;   // word parked, wait for drain
				end
			end
			default: state_d = state_q;  // halted until reset
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q     <= IFU_IDLE;
			pc_q        <= RESET_PC;
			stale_q     <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
			// apb cannot abort, so remember to throw the data away
			if (flush_i && (state_q == IFU_SETUP || (state_q == IFU_ACCESS && !mem_if.pready)))
				stale_q <= 1'b1;
			else if (done)
				stale_q <= 1'b0;
			if (flush_i)
				buf_valid_q <= 1'b0;  // parked word is wrong path
			else if (buf_valid_q && fetch_if.allowin)
				buf_valid_q <= 1'b0;
			else if (park)
				buf_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (state_d == IFU_SETUP)
			paddr_q <= pc_d;  // latched on entry to setup
		if (park) begin
			buf_inst_q <= mem_if.prdata;
			buf_pc_q   <= paddr_q;
		end
	end

endmodule

`default_nettype wire

// File: rtl/imem_apb.sv
// instruction ram behind an apb read slave
// 256 words, loaded through a side port, with lfsr-driven wait states
`timescale 1ns/10ps
`default_nettype none

module imem_apb (
	input  logic                 clock,
	input  logic                 reset,
	apb_rd_if.slave              bus_if,
	input  logic                 load_we_i,
	input  fetch_pkg::imem_idx_t load_idx_i,
	input  fetch_pkg::word_t     load_data_i
);
	import fetch_pkg::*;

	word_t     mem [0:IMEM_WORDS-1];
	logic [7:0] lfsr_q;   // free running wait source
	logic       lfsr_fb;
	logic [1:0] wait_q;   // access cycles left before pready
	imem_idx_t  rd_idx;
	logic       setup;
	logic       access;

	assign rd_idx = bus_if.paddr[9:2];  // wraps every 1 KiB
	assign setup  = bus_if.psel && !bus_if.penable;
	assign access = bus_if.psel && bus_if.penable;

	// x^8 + x^6 + x^5 + x^4 + 1
	assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

	always_ff @(posedge clock) begin
		if (load_we_i)
			mem[load_idx_i] <= load_data_i;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lfsr_q <= 8'h5a;  // any nonzero seed
			wait_q <= 2'd0;
		end else begin
			lfsr_q <= {lfsr_q[6:0], lfsr_fb};
			if (setup)
				wait_q <= lfsr_q[1:0];      // 0..3 extra access cycles
			else if (access && wait_q != 2'd0)
				wait_q <= wait_q - 2'd1;
		end
	end

	assign bus_if.pready = access && (wait_q == 2'd0);
	assign bus_if.prdata = mem[rd_idx];  // async read, sampled at pready

endmodule

`default_nettype wire

// File: rtl/predecode_stage.sv
// predecode stage, last stage of the front end
// registers the word with its class, resolves the redirect priority
// on accept and latches halt on ebreak
`timescale 1ns/10ps
`default_nettype none

module predecode_stage (
	input  logic                   clock,
	input  logic                   reset,
	fetch_dec_if.sink              fetch_if,
	output logic                   out_valid_o,
	input  logic                   out_ready_i,
	output fetch_pkg::word_t       out_inst_o,
	output fetch_pkg::addr_t       out_pc_o,
	output fetch_pkg::inst_class_t out_class_o,
	input  logic                   branch_taken_i,
	input  fetch_pkg::addr_t       branch_target_i,
	input  logic                   jmp_i,
	input  fetch_pkg::addr_t       jmp_target_i,
	input  logic                   csr_jmp_i,
	input  fetch_pkg::addr_t       csr_pc_i,
	output logic                   flush_o,
	output fetch_pkg::addr_t       flush_pc_o,
	output logic                   halt_o
);
	import fetch_pkg::*;

	logic        valid_q;
	logic        halt_q;     // sticky after ebreak
	word_t       inst_q;
	addr_t       pc_q;
	inst_class_t class_q;
	logic        accept;     // execute takes the word this edge
	logic        redirect;
	logic        is_ebreak;
	logic        kill;       // word here ends the current path
	logic        load;

	// supported subset check, anything else is illegal
	function automatic inst_class_t classify(input word_t w);
		logic [2:0]  f3;
		logic [6:0]  f7;
		inst_class_t cls;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			OPC_LUI, OPC_AUIPC, OPC_OP: cls = CLS_ALU;
			OPC_OP_IMM: begin
				if (f3 == 3'b001)
					cls = (f7 == 7'h00) ? CLS_ALU : CLS_ILLEGAL;  // slli
				else if (f3 == 3'b101)
					cls = (f7 == 7'h00 || f7 == 7'h20) ? CLS_ALU : CLS_ILLEGAL;
				else
					cls = CLS_ALU;
			end
			OPC_LOAD:   cls = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? CLS_LOAD : CLS_ILLEGAL;
			OPC_STORE:  cls = (f3 <= 3'd2) ? CLS_STORE : CLS_ILLEGAL;  // sb sh sw
			OPC_BRANCH: cls = CLS_BRANCH;
			OPC_JAL:    cls = CLS_JUMP;
			OPC_JALR:   cls = (f3 == 3'd0) ? CLS_JUMP : CLS_ILLEGAL;
			OPC_SYSTEM: cls = (f3 == 3'd1 || f3 == 3'd2) ? CLS_SYSTEM : CLS_ILLEGAL;  // csrrw csrrs
			default:    cls = CLS_ILLEGAL;
		endcase
		// exact encodings override the opcode rule
		if (w == ECALL_WORD || w == EBREAK_WORD || w == MRET_WORD || w == FENCEI_WORD)
			cls = CLS_SYSTEM;
		return cls;
	endfunction

	assign accept    = valid_q && out_ready_i;
	assign redirect  = branch_taken_i || jmp_i || csr_jmp_i;
	assign is_ebreak = (inst_q == EBREAK_WORD);
	assign kill      = accept && (redirect || is_ebreak);

	// refuse the next word when this one flushes or halts
	assign fetch_if.allowin = !halt_q && !kill && (!valid_q || out_ready_i);
	assign load = fetch_if.valid && fetch_if.allowin;

	assign flush_o    = accept && redirect;
	assign flush_pc_o = branch_taken_i ? branch_target_i :
	                    (jmp_i ? jmp_target_i : csr_pc_i);  // branch > jump > csr
	assign halt_o     = halt_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			halt_q  <= 1'b0;
		end else begin
			if (accept && is_ebreak)
				halt_q <= 1'b1;
			if (load)
				valid_q <= 1'b1;
			else if (accept)
				valid_q <= 1'b0;  // also empties on flush
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			inst_q  <= fetch_if.inst;
			pc_q    <= fetch_if.pc;
			class_q <= classify(fetch_if.inst);
		end
	end

	assign out_valid_o = valid_q;
	assign out_inst_o  = inst_q;
	assign out_pc_o    = pc_q;
	assign out_class_o = class_q;

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
// instruction fetch front end top level
// fetch stage, apb instruction ram and predecode, plain ports only
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load_we_i,    // ram preload
	input  fetch_pkg::imem_idx_t   load_idx_i,
	input  fetch_pkg::word_t       load_data_i,
	output logic                   out_valid_o,  // to execute
	input  logic                   out_ready_i,
	output fetch_pkg::word_t       out_inst_o,
	output fetch_pkg::addr_t       out_pc_o,
	output fetch_pkg::inst_class_t out_class_o,
	input  logic                   branch_taken_i,  // resolved flow, sampled on accept
	input  fetch_pkg::addr_t       branch_target_i,
	input  logic                   jmp_i,
	input  fetch_pkg::addr_t       jmp_target_i,
	input  logic                   csr_jmp_i,
	input  fetch_pkg::addr_t       csr_pc_i
);
	import fetch_pkg::*;

	logic  flush;
	addr_t flush_pc;
	logic  halt;

	apb_rd_if    apb0 ();
	fetch_dec_if fdec0 ();

	ifu_stage ifu0 (
		.clock      (clock),
		.reset      (reset),
		.fetch_if   (fdec0.source),
		.mem_if     (apb0.master),
		.flush_i    (flush),
		.flush_pc_i (flush_pc),
		.halt_i     (halt)
	);

	imem_apb imem0 (
		.clock       (clock),
		.reset       (reset),
		.bus_if      (apb0.slave),
		.load_we_i   (load_we_i),
		.load_idx_i  (load_idx_i),
		.load_data_i (load_data_i)
	);

	predecode_stage pdec0 (
		.clock           (clock),
		.reset           (reset),
		.fetch_if        (fdec0.sink),
		.out_valid_o     (out_valid_o),
		.out_ready_i     (out_ready_i),
		.out_inst_o      (out_inst_o),
		.out_pc_o        (out_pc_o),
		.out_class_o     (out_class_o),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.jmp_i           (jmp_i),
		.jmp_target_i    (jmp_target_i),
		.csr_jmp_i       (csr_jmp_i),
		.csr_pc_i        (csr_pc_i),
		.flush_o         (flush),
		.flush_pc_o      (flush_pc),
		.halt_o          (halt)
	);

endmodule

`default_nettype wire

// File: bench/fetch_model.svh
// reference model for the fetch front end testbench
// ram image, expected pc sequence, class rule and typed compare tasks
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

word_t model_mem [0:IMEM_WORDS-1];  // copy of the loaded ram
addr_t exp_pc;                      // pc of the next word due out

// redirect priority on accept
function automatic addr_t next_pc(input addr_t pc, input logic bt, input addr_t bt_pc,
		input logic jp, input addr_t jp_pc, input logic cj, input addr_t cj_pc);
	if (bt)
		return bt_pc;  // taken branch first
	if (jp)
		return jp_pc;
	if (cj)
		return cj_pc;  // trap or return last
	return pc + 32'd4;
endfunction

// supported rv32i subset
function automatic inst_class_t expected_class(input word_t w);
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	opc = w[6:0];
	f3  = w[14:12];
	f7  = w[31:25];
	if (w == ECALL_WORD || w == EBREAK_WORD || w == MRET_WORD || w == FENCEI_WORD)
		return CLS_SYSTEM;
	if (opc == OPC_LUI || opc == OPC_AUIPC || opc == OPC_OP)
		return CLS_ALU;
	if (opc == OPC_OP_IMM) begin
		if (f3 == 3'd1 && f7 != 7'h00)
			return CLS_ILLEGAL;  // bad slli
		if (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)
			return CLS_ILLEGAL;  // bad srli/srai
		return CLS_ALU;
	end
	if (opc == OPC_LOAD && f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7)
		return CLS_LOAD;
	if (opc == OPC_STORE && f3 < 3'd3)
		return CLS_STORE;
	if (opc == OPC_BRANCH)
		return CLS_BRANCH;
	if (opc == OPC_JAL || (opc == OPC_JALR && f3 == 3'd0))
		return CLS_JUMP;
	if (opc == OPC_SYSTEM && (f3 == 3'd1 || f3 == 3'd2))
		return CLS_SYSTEM;
	return CLS_ILLEGAL;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp) begin
		$display("** Error: %s expected %h actual %h", name, exp, act);
		stop_with_failure();
	end
endtask

task automatic check_addr(input string name, input addr_t exp, input addr_t act);
	if (act !== exp) begin
		$display("** Error: %s expected %h actual %h", name, exp, act);
		stop_with_failure();
	end
endtask

task automatic check_class(input string name, input inst_class_t exp, input inst_class_t act);
	if (act !== exp) begin
		$display("** Error: %s expected %h actual %h", name, exp, act);
		stop_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("** Error: %s expected %h actual %h", name, exp, act);
		stop_with_failure();
	end
endtask

`endif

// File: bench/fetch_tb.sv
// testbench for the instruction fetch front end
// random ram image, back-pressure and redirects checked against a model,
// ends by fetching an ebreak and watching fetch stay halted
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;
	import fetch_pkg::*;

	localparam int          NUM_ACCEPTS    = 2000;
	localparam int          TIMEOUT_CYCLES = NUM_ACCEPTS * 40 + IMEM_WORDS + 100;
	localparam logic [31:0] RAND_SEED      = 32'hdb448cd3;
	localparam imem_idx_t   HALT_IDX       = 8'hc4;  // only ebreak in the ram
	localparam addr_t       HALT_ADDR      = RESET_PC + {22'd0, HALT_IDX, 2'b00};

	logic        clock;
	logic        reset;
	logic        load_we;
	imem_idx_t   load_idx;
	word_t       load_data;
	logic        out_valid;
	logic        out_ready;
	word_t       out_inst;
	addr_t       out_pc;
	inst_class_t out_class;
	logic        branch_taken;
	addr_t       branch_target;
	logic        jmp;
	addr_t       jmp_target;
	logic        csr_jmp;
	addr_t       csr_pc;
	int          cycles;

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "fetch_model.svh"

	fetch_top dut0 (
		.clock           (clock),
		.reset           (reset),
		.load_we_i       (load_we),
		.load_idx_i      (load_idx),
		.load_data_i     (load_data),
		.out_valid_o     (out_valid),
		.out_ready_i     (out_ready),
		.out_inst_o      (out_inst),
		.out_pc_o        (out_pc),
		.out_class_o     (out_class),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.jmp_i           (jmp),
		.jmp_target_i    (jmp_target),
		.csr_jmp_i       (csr_jmp),
		.csr_pc_i        (csr_pc)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;  // 10 ns period

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	function automatic logic [6:0] valid_opcode(input int unsigned n);
		case (n)
			0:       return OPC_LUI;
			1:       return OPC_AUIPC;
			2:       return OPC_JAL;
			3:       return OPC_JALR;
			4:       return OPC_BRANCH;
			5:       return OPC_LOAD;
			6:       return OPC_STORE;
			7:       return OPC_OP_IMM;
			8:       return OPC_OP;
			9:       return OPC_SYSTEM;
			default: return OPC_MISC_MEM;
		endcase
	endfunction

	function automatic addr_t aligned_target();
		return addr_t'($urandom) & 32'hffff_fffc;
	endfunction

	// random ram image through the load port, mirrored in the model
	task automatic load_ram();
		word_t w;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			w = $urandom;
			if (i % 3 == 0)
				w[6:0] = valid_opcode($urandom % 11);  // hit real encodings
			if (w == EBREAK_WORD)
				w[31] = 1'b1;  // no stray halt
			if (i == 1)
				w = ECALL_WORD;
			else if (i == 2)
				w = MRET_WORD;
			else if (i == 3)
				w = FENCEI_WORD;
			else if (i == int'(HALT_IDX))
				w = EBREAK_WORD;
			model_mem[i] = w;
			@(negedge clock);
			load_we   = 1'b1;
			load_idx  = imem_idx_t'(i);
			load_data = w;
		end
		@(negedge clock);
		load_we = 1'b0;
	endtask

	// redirect on about a quarter of cycles, any flag mix
	task automatic pick_redirect();
		logic [2:0] flags;
		flags = 3'b000;
		if ($urandom % 4 == 0)
			flags = 3'($urandom % 7 + 1);
		branch_taken  = flags[2];
		jmp           = flags[1];
		csr_jmp       = flags[0];
		branch_target = aligned_target();
		jmp_target    = aligned_target();
		csr_pc        = aligned_target();
	endtask

	initial begin
		int          accepts;
		logic        held;     // stalled word last cycle
		logic        halted;
		addr_t       nxt;
		word_t       prev_inst;
		addr_t       prev_pc;
		inst_class_t prev_class;
		cycles        = 0;
		reset         = 1'b1;
		load_we       = 1'b0;
		load_idx      = '0;
		load_data     = '0;
		out_ready     = 1'b0;
		branch_taken  = 1'b0;
		branch_target = '0;
		jmp           = 1'b0;
		jmp_target    = '0;
		csr_jmp       = 1'b0;
		csr_pc        = '0;
		void'($urandom(RAND_SEED));
		load_ram();
		repeat (3) @(negedge clock);  // reset held 3 more cycles
		reset   = 1'b0;
		exp_pc  = RESET_PC;
		accepts = 0;
		held    = 1'b0;
		halted  = 1'b0;
		while (!halted) begin
			@(negedge clock);
			if (held) begin
				check_bit("out_valid_o", 1'b1, out_valid);
				check_word("out_inst_o", prev_inst, out_inst);
				check_addr("out_pc_o", prev_pc, out_pc);
				check_class("out_class_o", prev_class, out_class);
			end
			if (out_valid) begin
				check_addr("out_pc_o", exp_pc, out_pc);
				check_word("out_inst_o", model_mem[exp_pc[9:2]], out_inst);
				check_class("out_class_o", expected_class(model_mem[exp_pc[9:2]]), out_class);
			end
			out_ready = ($urandom % 100) < 60;
			pick_redirect();
			if (out_valid && out_ready) begin
				if (out_inst == EBREAK_WORD) begin
					halted = 1'b1;  // redirects must not matter now
				end else begin
					nxt = next_pc(out_pc, branch_taken, branch_target, jmp, jmp_target,
						csr_jmp, csr_pc);
					if (accepts == NUM_ACCEPTS - 1) begin
						branch_taken  = 1'b1;  // steer onto the ebreak
						branch_target = HALT_ADDR;
					end else if (nxt[9:2] == HALT_IDX) begin
						branch_taken  = 1'b1;  // keep clear of the ebreak
						branch_target = nxt + 32'd8;
					end
					exp_pc  = next_pc(out_pc, branch_taken, branch_target, jmp, jmp_target,
						csr_jmp, csr_pc);
					accepts = accepts + 1;
				end
			end
			held       = out_valid && !out_ready;
			prev_inst  = out_inst;
			prev_pc    = out_pc;
			prev_class = out_class;
		end
		repeat (50) begin
			@(negedge clock);
			check_bit("out_valid_o", 1'b0, out_valid);
			out_ready = ($urandom % 100) < 60;
			pick_redirect();
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
rtl/fetch_pkg.sv
rtl/apb_rd_if.sv
rtl/fetch_dec_if.sv
rtl/ifu_stage.sv
rtl/imem_apb.sv
rtl/predecode_stage.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

// File: Makefile
# Verilator build for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
